//--- design/chan_fifo.sv
`default_nettype none
`include "mosaic_defines.svh"

module chan_fifo #(
    parameter int DEPTH = `MOSAIC_CHAN_DEPTH // power of two
) (
    input  wire         clk_fifo,
    input  wire         locked_calib_rst_n,
    input  wire         flush,    // sync clear, read disabled
    input  wire         wr_en,
    input  wire  [31:0] wr_data,
    input  wire         rd_en,    // pop
    output logic [31:0] rd_data,  // show-ahead head word
    output logic        full
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;  // occupancy, 0..DEPTH
    logic          empty;
    logic          wr_ok;  // write accepted
    logic          rd_ok;  // pop accepted

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));
    assign wr_ok = wr_en && !full && !flush;  // write into full is dropped
    assign rd_ok = rd_en && !empty && !flush; // pop on empty ignored

    assign rd_data = empty ? 32'h0 : mem[rd_ptr]; // zero when nothing held

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo) begin
        if (wr_ok) mem[wr_ptr] <= wr_data;
    end

    //////////////////////////////////////////////////
    // pointers and count
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo or negedge locked_calib_rst_n) begin
        if (!locked_calib_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin // empty the buffer
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/key_toggle.sv
`default_nettype none
`include "mosaic_defines.svh"

module key_toggle (
    input  wire  clk_fifo,
    input  wire  locked_calib_rst_n,
    input  wire  key_in,        // active low
    output logic key_state_out  // toggled level, read enable
);

    localparam int DEB   = `MOSAIC_KEY_DEBOUNCE;
    localparam int CNT_W = $clog2(DEB + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEB - 1);

    mosaic_pkg::key_state_e state;
    logic [CNT_W-1:0]       deb_cnt; // stable cycle count

    //////////////////////////////////////////////////
    // debounce fsm, toggle on accepted press
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo or negedge locked_calib_rst_n) begin
        if (!locked_calib_rst_n) begin
            state         <= mosaic_pkg::key_idle;
            deb_cnt       <= '0;
            key_state_out <= 1'b0;
        end else begin
            case (state)
                mosaic_pkg::key_idle: begin
                    deb_cnt <= '0;
                    if (!key_in) state <= mosaic_pkg::key_press_wait; // edge seen
                end
                mosaic_pkg::key_press_wait: begin
                    if (key_in) begin // bounce, start over
                        state <= mosaic_pkg::key_idle;
                    end else if (deb_cnt == CNT_LAST) begin
                        state         <= mosaic_pkg::key_held;
                        key_state_out <= ~key_state_out; // accepted press
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                mosaic_pkg::key_held: begin
                    deb_cnt <= '0;
                    if (key_in) state <= mosaic_pkg::key_release_wait;
                end
                default: begin // release wait
                    if (!key_in) begin // still bouncing
                        state <= mosaic_pkg::key_held;
                    end else if (deb_cnt == CNT_LAST) begin
                        state <= mosaic_pkg::key_idle; // clean release
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/mosaic_defines.svh
`ifndef MOSAIC_DEFINES_SVH
`define MOSAIC_DEFINES_SVH

//////////////////////////////////////////////////
// raster timing, shrunk frame
//////////////////////////////////////////////////
`define MOSAIC_H_ACTIVE     16   // active pixels per line
`define MOSAIC_H_FP         2    // front porch
`define MOSAIC_H_SYNC       3    // hsync width
`define MOSAIC_H_BP         3    // back porch, line totals 24

`define MOSAIC_V_ACTIVE     12   // active lines per frame
`define MOSAIC_V_FP         1    // in lines
`define MOSAIC_V_SYNC       2    // vsync width in lines
`define MOSAIC_V_BP         2    // frame totals 17 lines

//////////////////////////////////////////////////
// quadrant split
//////////////////////////////////////////////////
`define MOSAIC_DIV_H        8    // half of active width
`define MOSAIC_DIV_V        6    // half of active height

//////////////////////////////////////////////////
// buffers and key
//////////////////////////////////////////////////
`define MOSAIC_CHAN_DEPTH   16   // words per channel buffer
`define MOSAIC_KEY_DEBOUNCE 16   // stable cycles before key state is taken

`endif

//--- design/mosaic_pkg.sv
`default_nettype none

package mosaic_pkg;

    // channel number equals quadrant
    typedef enum logic [1:0] {
        quad_a = 2'd0, // top left
        quad_b = 2'd1, // top right
        quad_c = 2'd2, // bottom left
        quad_d = 2'd3  // bottom right
    } quadrant_e;

    typedef enum logic [1:0] {
        key_idle         = 2'd0, // waiting for a press
        key_press_wait   = 2'd1, // press debounce
        key_held         = 2'd2, // press accepted, key still down
        key_release_wait = 2'd3  // release debounce
    } key_state_e;

    typedef struct packed {
        logic [7:0] red;   // bits 31:24 of channel word
        logic [7:0] green;
        logic [7:0] blue;  // bits 15:8
    } pixel_t;

    typedef struct packed {
        logic hsync; // active high
        logic vsync; // active high
        logic de;    // pixel valid
    } sync_t;

    typedef struct packed {
        logic        en;   // write strobe
        quadrant_e   chan; // target buffer
        logic [31:0] data;
    } chan_wr_t;

endpackage

`default_nettype wire

//--- design/mosaic_top.sv
`default_nettype none

module mosaic_top (
    input  wire                       clk_fifo,
    input  wire                       locked_calib_rst_n,
    input  wire                       key_in,        // active low push key
    input  wire mosaic_pkg::chan_wr_t chan_wr,       // memory side write
    output wire                       key_state_out, // read enable level
    output wire [3:0]                 chan_full,
    output wire mosaic_pkg::sync_t    video,
    output wire mosaic_pkg::pixel_t   rgb_out
);

    wire                     rd_mem_enable; // from key toggle
    wire [3:0][31:0]         chan_head;     // show-ahead words
    wire [3:0]               pop;           // one-hot from router
    wire                     pix_req;
    mosaic_pkg::pixel_t      pixel_sel;     // router to raster

    //////////////////////////////////////////////////
    // key
    //////////////////////////////////////////////////
    key_toggle u_key_toggle (
        .clk_fifo           (clk_fifo),
        .locked_calib_rst_n (locked_calib_rst_n),
        .key_in             (key_in),
        .key_state_out      (rd_mem_enable)
    );

    assign key_state_out = rd_mem_enable;

    //////////////////////////////////////////////////
    // channel buffers a..d
    //////////////////////////////////////////////////
    for (genvar i = 0; i < 4; i++) begin : g_chan
        chan_fifo u_chan_fifo (
            .clk_fifo           (clk_fifo),
            .locked_calib_rst_n (locked_calib_rst_n),
            .flush              (~rd_mem_enable), // cleared while reading off
            .wr_en              (chan_wr.en && (chan_wr.chan == mosaic_pkg::quadrant_e'(i))),
            .wr_data            (chan_wr.data),
            .rd_en              (pop[i]),
            .rd_data            (chan_head[i]),
            .full               (chan_full[i])
        );
    end

    //////////////////////////////////////////////////
    // routing and raster
    //////////////////////////////////////////////////
    quadrant_router u_quadrant_router (
        .clk_fifo           (clk_fifo),
        .locked_calib_rst_n (locked_calib_rst_n),
        .rd_mem_enable      (rd_mem_enable),
        .pix_req            (pix_req),
        .chan_head          (chan_head),
        .rd_en              (pop),
        .pixel              (pixel_sel)
    );

    raster_timing u_raster_timing (
        .clk_fifo           (clk_fifo),
        .locked_calib_rst_n (locked_calib_rst_n),
        .rd_mem_enable      (rd_mem_enable),
        .pixel              (pixel_sel),
        .pix_req            (pix_req),
        .video              (video),
        .rgb_out            (rgb_out)
    );

endmodule

`default_nettype wire

//--- design/quadrant_router.sv
`default_nettype none
`include "mosaic_defines.svh"

module quadrant_router (
    input  wire                     clk_fifo,
    input  wire                     locked_calib_rst_n,
    input  wire                     rd_mem_enable,
    input  wire                     pix_req,    // one strobe per active pixel
    input  wire  [3:0][31:0]        chan_head,  // head word of each channel
    output logic [3:0]              rd_en,      // one-hot pop
    output mosaic_pkg::pixel_t      pixel       // selected pixel, same cycle
);

    localparam int HW = $clog2(`MOSAIC_H_ACTIVE);
    localparam int VW = $clog2(`MOSAIC_V_ACTIVE);
    localparam logic [HW-1:0] H_LAST = HW'(`MOSAIC_H_ACTIVE - 1);
    localparam logic [VW-1:0] V_LAST = VW'(`MOSAIC_V_ACTIVE - 1);
    localparam logic [HW-1:0] H_DIV  = HW'(`MOSAIC_DIV_H);
    localparam logic [VW-1:0] V_DIV  = VW'(`MOSAIC_DIV_V);

    logic [HW-1:0]         cnt_h;     // screen column
    logic [VW-1:0]         cnt_v;     // screen row
    logic                  in_right;  // columns B, D
    logic                  in_bottom; // rows C, D
    mosaic_pkg::quadrant_e quad;

    //////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo or negedge locked_calib_rst_n) begin
        if (!locked_calib_rst_n) begin
            cnt_h <= '0;
            cnt_v <= '0;
        end else if (!rd_mem_enable) begin // restart with the raster
            cnt_h <= '0;
            cnt_v <= '0;
        end else if (pix_req) begin
            if (cnt_h == H_LAST) begin
                cnt_h <= '0;
                cnt_v <= (cnt_v == V_LAST) ? '0 : cnt_v + 1'b1; // frame wrap
            end else begin
                cnt_h <= cnt_h + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // quadrant select
    //////////////////////////////////////////////////
    assign in_right  = (cnt_h >= H_DIV);
    assign in_bottom = (cnt_v >= V_DIV);
    assign quad      = mosaic_pkg::quadrant_e'({in_bottom, in_right}); // a b c d = 0..3

    assign rd_en = pix_req ? (4'b0001 << quad) : 4'b0000; // steer strobe
    assign pixel = mosaic_pkg::pixel_t'(chan_head[quad][31:8]); // upper 24 bits

endmodule

`default_nettype wire

//--- design/raster_timing.sv
`default_nettype none
`include "mosaic_defines.svh"

module raster_timing (
    input  wire                     clk_fifo,
    input  wire                     locked_calib_rst_n,
    input  wire                     rd_mem_enable,
    input  wire mosaic_pkg::pixel_t pixel,    // from router
    output logic                    pix_req,  // fetch strobe
    output mosaic_pkg::sync_t       video,    // registered syncs and de
    output mosaic_pkg::pixel_t      rgb_out   // registered pixel
);

    // line layout: active, front porch, sync, back porch
    localparam int H_TOTAL = `MOSAIC_H_ACTIVE + `MOSAIC_H_FP + `MOSAIC_H_SYNC + `MOSAIC_H_BP;
    localparam int V_TOTAL = `MOSAIC_V_ACTIVE + `MOSAIC_V_FP + `MOSAIC_V_SYNC + `MOSAIC_V_BP;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);
    localparam logic [VW-1:0] V_LAST   = VW'(V_TOTAL - 1);
    localparam logic [HW-1:0] H_ACT    = HW'(`MOSAIC_H_ACTIVE);
    localparam logic [VW-1:0] V_ACT    = VW'(`MOSAIC_V_ACTIVE);
    localparam logic [HW-1:0] HS_BEG   = HW'(`MOSAIC_H_ACTIVE + `MOSAIC_H_FP);
    localparam logic [HW-1:0] HS_END   = HW'(`MOSAIC_H_ACTIVE + `MOSAIC_H_FP + `MOSAIC_H_SYNC);
    localparam logic [VW-1:0] VS_BEG   = VW'(`MOSAIC_V_ACTIVE + `MOSAIC_V_FP);
    localparam logic [VW-1:0] VS_END   = VW'(`MOSAIC_V_ACTIVE + `MOSAIC_V_FP + `MOSAIC_V_SYNC);

    logic [HW-1:0] h_cnt;     // column incl. blanking
    logic [VW-1:0] v_cnt;     // line incl. blanking
    logic          h_active;
    logic          v_active;
    logic          hsync_c;   // unregistered syncs
    logic          vsync_c;

    //////////////////////////////////////////////////
    // line and frame counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo or negedge locked_calib_rst_n) begin
        if (!locked_calib_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!rd_mem_enable) begin // hold at first active pixel
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    assign h_active = (h_cnt < H_ACT);
    assign v_active = (v_cnt < V_ACT);
    assign hsync_c  = (h_cnt >= HS_BEG) && (h_cnt < HS_END); // 3 cycles
    assign vsync_c  = (v_cnt >= VS_BEG) && (v_cnt < VS_END); // 2 whole lines

    // counters sit at 0,0 while disabled, so gate the request
    assign pix_req = rd_mem_enable && h_active && v_active;

    //////////////////////////////////////////////////
    // output registers, one cycle after pix_req
    //////////////////////////////////////////////////
    always_ff @(posedge clk_fifo or negedge locked_calib_rst_n) begin
        if (!locked_calib_rst_n) begin
            video   <= '0;
            rgb_out <= '0;
        end else if (!rd_mem_enable) begin
            video   <= '0;
            rgb_out <= '0;
        end else begin
            video.hsync <= hsync_c;
            video.vsync <= vsync_c;
            video.de    <= pix_req;
            rgb_out     <= pix_req ? pixel : '0; // black in blanking
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/mosaic_pkg.sv
design/key_toggle.sv
design/chan_fifo.sv
design/quadrant_router.sv
design/raster_timing.sv
design/mosaic_top.sv
tests/tb_clock.sv
tests/mosaic_checker.sv
tests/tb_mosaic.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mosaic testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mosaic -f filelist.f -o sim_mosaic \
    > build.log 2>&1 \
    && ./obj_dir/sim_mosaic > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

//--- tests/mosaic_checker.sv
`default_nettype none
`include "mosaic_defines.svh"

module mosaic_checker (
    input  wire                       clk_fifo,
    input  wire                       locked_calib_rst_n,
    input  wire                       key_in,
    input  wire mosaic_pkg::chan_wr_t chan_wr,
    input  wire                       key_state_out,
    input  wire [3:0]                 chan_full,
    input  wire mosaic_pkg::sync_t    video,
    input  wire mosaic_pkg::pixel_t   rgb_out,
    output int                        pix_errs,
    output int                        sync_errs,
    output int                        full_errs,
    output int                        key_errs
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_TOT = `MOSAIC_H_ACTIVE + `MOSAIC_H_FP + `MOSAIC_H_SYNC + `MOSAIC_H_BP;
    localparam int V_TOT = `MOSAIC_V_ACTIVE + `MOSAIC_V_FP + `MOSAIC_V_SYNC + `MOSAIC_V_BP;
    localparam int HS_BEG = `MOSAIC_H_ACTIVE + `MOSAIC_H_FP;
    localparam int VS_BEG = `MOSAIC_V_ACTIVE + `MOSAIC_V_FP;
    localparam int DE_PER_FRAME = `MOSAIC_H_ACTIVE * `MOSAIC_V_ACTIVE;

    logic [31:0] q [4][$];      // accepted words per channel
    logic [2:0]  exp_video;     // hsync vsync de
    logic [23:0] exp_rgb;
    int          h;             // model raster column
    int          v;             // model raster line
    int          low_run;       // cycles key_in seen low
    logic        prev_key_out;
    logic        prev_vs;
    int          de_cnt;
    int          cyc_cnt;
    int          frames;

    initial begin
        pix_errs  = 0;
        sync_errs = 0;
        full_errs = 0;
        key_errs  = 0;
    end

    // upper 24 bits of the oldest unread word of the owning quadrant
    function automatic logic [23:0] ref_pixel(input int col, input int row);
        int          qd;
        logic [31:0] word;
        qd   = ((row >= `MOSAIC_DIV_V) ? 2 : 0) + ((col >= `MOSAIC_DIV_H) ? 1 : 0);
        word = 32'h0; // empty buffer shows zero
        if (q[qd].size() > 0) word = q[qd].pop_front();
        return word[31:8];
    endfunction

    //////////////////////////////////////////////////
    // compare pre-edge samples then advance the model
    //////////////////////////////////////////////////
    always @(posedge clk_fifo) begin
        bit req;
        if (!locked_calib_rst_n) begin
            for (int i = 0; i < 4; i++) q[i].delete();
            exp_video    = '0;
            exp_rgb      = '0;
            h            = 0;
            v            = 0;
            low_run      = 0;
            prev_key_out = 1'b0;
            prev_vs      = 1'b0;
            de_cnt       = 0;
            cyc_cnt      = 0;
            frames       = 0;
        end else begin
            if (video !== exp_video) begin
                sync_errs++;
                $display("FAIL video: expected %h actual %h", exp_video, video);
            end
            if (rgb_out !== exp_rgb) begin
                pix_errs++;
                $display("FAIL rgb_out: expected %h actual %h", exp_rgb, rgb_out);
            end
            for (int i = 0; i < 4; i++) begin
                if (chan_full[i] !== (q[i].size() == `MOSAIC_CHAN_DEPTH)) begin
                    full_errs++;
                    $display("FAIL chan_full[%0d]: expected %h actual %h", i,
                             q[i].size() == `MOSAIC_CHAN_DEPTH, chan_full[i]);
                end
            end
            // toggle lands on the edge after DEB+1 low samples
            if (key_state_out !== prev_key_out && low_run != `MOSAIC_KEY_DEBOUNCE + 1) begin
                key_errs++;
                $display("FAIL key_state_out delay: expected %h actual %h",
                         `MOSAIC_KEY_DEBOUNCE + 1, low_run);
            end
            prev_key_out = key_state_out;
            low_run      = key_in ? 0 : low_run + 1;
            // 192 de cycles and 408 cycles per vsync
            if (video.vsync && !prev_vs) begin
                if (frames > 0 && (de_cnt != DE_PER_FRAME || cyc_cnt != H_TOT * V_TOT)) begin
                    sync_errs++;
                    $display("frame shape wrong with %0d de cycles in %0d cycles",
                             de_cnt, cyc_cnt);
                end
                frames++;
                de_cnt  = 0;
                cyc_cnt = 0;
            end
            prev_vs = video.vsync;
            de_cnt  += video.de;
            cyc_cnt++;
            if (!key_state_out) begin // flushed and held
                for (int i = 0; i < 4; i++) q[i].delete();
                exp_video = '0;
                exp_rgb   = '0;
                h         = 0;
                v         = 0;
                frames    = 0;
            end else begin
                req = (h < `MOSAIC_H_ACTIVE) && (v < `MOSAIC_V_ACTIVE);
                exp_video = {h >= HS_BEG && h < HS_BEG + `MOSAIC_H_SYNC,
                             v >= VS_BEG && v < VS_BEG + `MOSAIC_V_SYNC, req};
                exp_rgb = '0;
                if (req) exp_rgb = ref_pixel(h, v);
                // a write into a full buffer leaves no trace
                if (chan_wr.en && !chan_full[chan_wr.chan]) begin
                    q[chan_wr.chan].push_back(chan_wr.data);
                end
                if (h == H_TOT - 1) begin
                    h = 0;
                    v = (v == V_TOT - 1) ? 0 : v + 1;
                end else begin
                    h++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk_fifo,
    output logic locked_calib_rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_fifo           = 1'b0;
        locked_calib_rst_n = 1'b0;                // held low from time zero
        repeat (10) @(posedge clk_fifo);
        locked_calib_rst_n <= 1'b1;               // released on an edge
    end

    always #4 clk_fifo = ~clk_fifo; // 8 ns period

endmodule

`default_nettype wire

//--- tests/tb_mosaic.sv
`default_nettype none
`include "mosaic_defines.svh"

module tb_mosaic;

    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk_fifo;
    logic                 locked_calib_rst_n;
    logic                 key_in;
    mosaic_pkg::chan_wr_t chan_wr;
    logic                 key_state_out;
    logic [3:0]           chan_full;
    mosaic_pkg::sync_t    video;
    mosaic_pkg::pixel_t   rgb_out;
    int                   pix_errs;
    int                   sync_errs;
    int                   full_errs;
    int                   key_errs;
    int                   timeouts;
    logic [31:0]          lcg_state;
    int                   rr;       // round-robin pointer
    bit                   feeding;

    tb_clock u_clock (.clk_fifo(clk_fifo), .locked_calib_rst_n(locked_calib_rst_n));

    mosaic_top dut (
        .clk_fifo(clk_fifo), .locked_calib_rst_n(locked_calib_rst_n), .key_in(key_in),
        .chan_wr(chan_wr), .key_state_out(key_state_out), .chan_full(chan_full),
        .video(video), .rgb_out(rgb_out)
    );

    mosaic_checker u_checker (
        .clk_fifo(clk_fifo), .locked_calib_rst_n(locked_calib_rst_n), .key_in(key_in),
        .chan_wr(chan_wr), .key_state_out(key_state_out), .chan_full(chan_full),
        .video(video), .rgb_out(rgb_out), .pix_errs(pix_errs), .sync_errs(sync_errs),
        .full_errs(full_errs), .key_errs(key_errs)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////////////////////////
    // feeder writes one word per cycle
    //////////////////////////////////////////////////
    always @(posedge clk_fifo) begin
        int cand;
        if (feeding) begin
            cand = rr; // write to rr is dropped when all are full
            for (int k = 3; k >= 0; k--) begin
                if (!chan_full[(rr + k) % 4]) cand = (rr + k) % 4;
            end
            lcg_state = lcg_next(lcg_state);
            chan_wr <= '{en: 1'b1, chan: mosaic_pkg::quadrant_e'(cand[1:0]), data: lcg_state};
            rr = (cand + 1) % 4;
        end
    end

    task automatic wait_key_level(input logic lvl, output bit ok);
        ok = 0;
        for (int n = 0; n < 4 * `MOSAIC_KEY_DEBOUNCE && !ok; n++) begin
            @(posedge clk_fifo);
            #1 ok = (key_state_out === lvl);
        end
        if (!ok) begin
            timeouts++;
            $display("key_state_out did not reach %0b in time", lvl);
        end
    endtask

    task automatic wait_frames(input int n, output bit ok);
        int   seen = 0;
        logic prev = 1'b0;
        for (int c = 0; c < n * 408 + 500 && seen < n; c++) begin
            @(posedge clk_fifo);
            if (video.vsync && !prev) seen++;
            prev = video.vsync;
        end
        ok = (seen == n);
        if (!ok) begin
            timeouts++;
            $display("only %0d of %0d frames seen before timeout", seen, n);
        end
    endtask

    // hold until the toggle and release cleanly
    task automatic press_key(input logic target, output bit ok);
        @(posedge clk_fifo) key_in <= 1'b0;
        wait_key_level(target, ok);
        repeat (5) @(posedge clk_fifo);
        key_in <= 1'b1;
        repeat (30) @(posedge clk_fifo);
    endtask

    task automatic run_sequence();
        bit ok;
        for (int c = 0; c < 100 && !locked_calib_rst_n; c++) @(posedge clk_fifo);
        if (!locked_calib_rst_n) begin
            timeouts++;
            $display("reset was not released in time");
            return;
        end
        repeat (3) @(posedge clk_fifo);
        feeding <= 1'b1;                   // dropped until enabled
        @(posedge clk_fifo) key_in <= 1'b0; // 5 cycle glitch
        repeat (5) @(posedge clk_fifo);
        key_in <= 1'b1;
        repeat (40) @(posedge clk_fifo);
        press_key(1'b1, ok);
        if (!ok) return;
        wait_frames(3, ok);
        if (!ok) return;
        press_key(1'b0, ok);               // flush everything
        if (!ok) return;
        press_key(1'b1, ok);
        if (!ok) return;
        wait_frames(3, ok);
    endtask

    initial begin
        key_in    = 1'b1;
        chan_wr   = '0;
        timeouts  = 0;
        lcg_state = 32'd28617;
        rr        = 0;
        feeding   = 0;
        run_sequence();
        @(posedge clk_fifo); // checker done with the last edge
        #1;
        $display("errors: pixel %0d sync %0d full %0d key %0d timeout %0d",
                 pix_errs, sync_errs, full_errs, key_errs, timeouts);
        if (pix_errs + sync_errs + full_errs + key_errs + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
